// ==== Bender.yml ====
package:
  name: mips_cpu_bus

sources:
  - files:
      - source/mips_pkg.sv
      - source/alu.sv
      - source/control_decoder.sv
      - source/register_file.sv
      - source/fetch_sequencer.sv
      - source/load_store_unit.sv
      - source/mips_cpu_bus.sv
  - target: simulation
    files:
      - sim/avalon_memory_model.sv
      - sim/tb_mips_cpu_bus.sv

// ==== all.f ====
source/mips_pkg.sv
source/alu.sv
source/control_decoder.sv
source/register_file.sv
source/fetch_sequencer.sv
source/load_store_unit.sv
source/mips_cpu_bus.sv
sim/avalon_memory_model.sv
sim/tb_mips_cpu_bus.sv

// ==== sim/avalon_memory_model.sv ====
`timescale 1ns/100ps

module avalon_memory_model (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::word_t    address,
    input  logic               read,
    input  logic               write,
    input  mips_pkg::word_t    writedata,
    input  mips_pkg::byte_en_t byteenable,
    output logic               waitrequest,
    output mips_pkg::word_t    readdata
);

    logic [31:0] words [16384];  // 64 KiB indexed by address[15:2]
    logic [31:0] lfsr;
    logic [31:0] lfsr_once;
    logic [31:0] lfsr_twice;
    logic [1:0]  wait_left;
    logic        busy;           // request seen and waits still running
    logic [13:0] index;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign index      = address[15:2];  // 0xBFC00000 and 0 regions alias
    assign lfsr_once  = lfsr_step(lfsr);
    assign lfsr_twice = lfsr_step(lfsr_once);

    initial begin
        waitrequest = 1'b1;
        readdata    = '0;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            waitrequest <= 1'b1;
            busy        <= 1'b0;
            wait_left   <= '0;
            readdata    <= '0;
            lfsr        <= 32'h2f41a3c2;
        end else if (!waitrequest) begin
            // transfer completes at this edge
            if (write) begin
                for (int b = 0; b < 4; b++) begin
                    if (byteenable[b]) words[index][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
            waitrequest <= 1'b1;
            busy        <= 1'b0;
        end else if (busy) begin
            if (wait_left == '0) begin
                waitrequest <= 1'b0;
                readdata    <= words[index];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end else if (read || write) begin
            wait_left <= {lfsr_once[0], lfsr_twice[0]};  // one step per bit
            lfsr      <= lfsr_twice;
            busy      <= 1'b1;
        end
    end

endmodule

// ==== sim/program_golden.hex ====
// columns: kind address value, all hex
// kind 0 preloads memory, kind 1 is a memory word after halt, kind 2 is v0 after halt
0 bfc00000 3c081234  // lui   t0, 0x1234
0 bfc00004 35085678  // ori   t0, t0, 0x5678
0 bfc00008 2409fffd  // addiu t1, zero, -3
0 bfc0000c 01095021  // addu  t2, t0, t1
0 bfc00010 01095823  // subu  t3, t0, t1
0 bfc00014 014b6024  // and   t4, t2, t3
0 bfc00018 01896826  // xor   t5, t4, t1
0 bfc0001c 0120702a  // slt   t6, t1, zero
0 bfc00020 0120782b  // sltu  t7, t1, zero
0 bfc00024 000e7100  // sll   t6, t6, 4
0 bfc00028 000d7f02  // srl   t7, t5, 28
0 bfc0002c 01ae1021  // addu  v0, t5, t6
0 bfc00030 004f1021  // addu  v0, v0, t7
0 bfc00034 24101000  // addiu s0, zero, 0x1000
0 bfc00038 ae0d0000  // sw    t5, 0(s0)
0 bfc0003c a20c0005  // sb    t4, 5(s0)
0 bfc00040 a20d000b  // sb    t5, 11(s0)
0 bfc00044 82090000  // lb    t1, 0(s0)
0 bfc00048 920a0000  // lbu   t2, 0(s0)
0 bfc0004c 8e0b0004  // lw    t3, 4(s0)
0 bfc00050 00491026  // xor   v0, v0, t1
0 bfc00054 004a1021  // addu  v0, v0, t2
0 bfc00058 004b1023  // subu  v0, v0, t3
0 bfc0005c 112a0001  // beq   t1, t2, bad (not taken)
0 bfc00060 152a0001  // bne   t1, t2, call (taken)
0 bfc00064 24420100  // bad:  addiu v0, v0, 0x100
0 bfc00068 0ff0001e  // call: jal func
0 bfc0006c 24420007  // addiu v0, v0, 7
0 bfc00070 10000003  // beq   zero, zero, done
0 bfc00074 24420200  // addiu v0, v0, 0x200
0 bfc00078 005f1021  // func: addu v0, v0, ra
0 bfc0007c 03e00008  // jr    ra
0 bfc00080 00000008  // done: jr zero
0 00001000 a5a5a5a5
0 00001004 11223344
0 00001008 55667788
1 00001000 edcba98c
1 00001004 11227144
1 00001008 8c667788
2 00000000 c0d1e5e1

// ==== sim/tb_mips_cpu_bus.sv ====
`timescale 1ns/100ps

module tb_mips_cpu_bus;

    localparam logic [31:0] boot_address = 32'hBFC00000;
    localparam int          halt_timeout = 5000;  // cycles

    logic               clk;
    logic               arst_n;
    logic               active;
    mips_pkg::word_t    register_v0;
    mips_pkg::word_t    address;
    logic               read;
    logic               write;
    mips_pkg::word_t    writedata;
    mips_pkg::byte_en_t byteenable;
    logic               waitrequest;
    mips_pkg::word_t    readdata;

    logic [31:0] exp_mem_addr [$];
    logic [31:0] exp_mem_data [$];
    logic [31:0] exp_v0;
    logic        have_v0;

    mips_cpu_bus dut0 (
        .clk, .arst_n, .active, .register_v0,
        .address, .read, .write, .writedata, .byteenable, .waitrequest, .readdata
    );

    avalon_memory_model mem0 (
        .clk, .arst_n, .address, .read, .write, .writedata, .byteenable,
        .waitrequest, .readdata
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // every word gets a value built from its full index
    task automatic fill_memory();
        for (int i = 0; i < 16384; i++) begin
            mem0.words[i] = {2'b10, i[13:0], 2'b01, ~i[13:0]};
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] value;
        fd = $fopen("sim/program_golden.hex", "r");
        if (fd == 0) begin
            abort_run("cannot open sim/program_golden.hex");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%h %h %h", kind, addr, value);  // comments give 0
                if (fields == 3) begin
                    case (kind)
                        32'd0: mem0.words[addr[15:2]] = value;
                        32'd1: begin
                            exp_mem_addr.push_back(addr);
                            exp_mem_data.push_back(value);
                        end
                        32'd2: begin
                            exp_v0  = value;
                            have_v0 = 1'b1;
                        end
                        default: abort_run("golden file holds an unknown record kind");
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int cycles;
        arst_n  = 1'b0;
        have_v0 = 1'b0;
        exp_v0  = '0;
        fill_memory();
        load_golden();
        if (!have_v0) abort_run("golden file has no expected v0 record");

        // first edge puts every flop into reset
        @(posedge clk);
        // bus stays quiet through reset
        repeat (16) begin
            @(negedge clk);
            compare_value("active", active, 32'd0);
            compare_value("read", read, 32'd0);
            compare_value("write", write, 32'd0);
        end
        @(posedge clk);
        arst_n <= 1'b1;

        cycles = 0;
        while (!read && cycles < 5) begin
            @(negedge clk);
            cycles++;
        end
        if (!read) abort_run("no instruction fetch within 5 cycles of reset release");
        compare_value("active", active, 32'd1);
        compare_value("address", address, boot_address);

        cycles = 0;
        while (active && cycles < halt_timeout) begin
            // instruction fetches use all four lanes
            if (read && address[31:16] == boot_address[31:16]) begin
                compare_value("byteenable", byteenable, 32'hF);
            end
            @(negedge clk);
            cycles++;
        end
        if (active) abort_run("cpu never halted");

        repeat (50) begin
            @(negedge clk);
            compare_value("active", active, 32'd0);
            compare_value("read", read, 32'd0);
            compare_value("write", write, 32'd0);
        end

        compare_value("register_v0", register_v0, exp_v0);
        foreach (exp_mem_addr[i]) begin
            compare_value($sformatf("mem[%h]", exp_mem_addr[i]),
                          mem0.words[exp_mem_addr[i][15:2]], exp_mem_data[i]);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    input  mips_pkg::alu_op_e op,
    output mips_pkg::word_t   result,
    output logic              zero
);

    mips_pkg::word_t diff;

    assign diff = a - b;
    assign zero = (diff == '0);  // branch compare of rs and rt

    always_comb begin
        case (op)
            mips_pkg::alu_add:  result = a + b;
            mips_pkg::alu_sub:  result = diff;
            mips_pkg::alu_and:  result = a & b;
            mips_pkg::alu_or:   result = a | b;
            mips_pkg::alu_xor:  result = a ^ b;
            mips_pkg::alu_nor:  result = ~(a | b);
            mips_pkg::alu_slt: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            mips_pkg::alu_sltu: begin
                result = {31'b0, a < b};
            end
            // shifts act on the rt operand
            mips_pkg::alu_sll:  result = b << shamt;
            mips_pkg::alu_srl:  result = b >> shamt;
            mips_pkg::alu_lui:  result = {b[15:0], 16'h0000};
            default:            result = '0;
        endcase
    end

endmodule

// ==== source/control_decoder.sv ====
`timescale 1ns/100ps

module control_decoder (
    input  mips_pkg::word_t instr,
    output mips_pkg::ctrl_t ctrl
);

    always_comb begin
        ctrl = '0;  // unknown opcode behaves as a nop
        case (mips_pkg::opcode_e'(instr[31:26]))
            mips_pkg::op_special: begin
                ctrl.reg_dst_rd = 1'b1;
                ctrl.reg_write  = 1'b1;
                case (mips_pkg::funct_e'(instr[5:0]))
                    mips_pkg::fn_sll:  ctrl.alu_op = mips_pkg::alu_sll;
                    mips_pkg::fn_srl:  ctrl.alu_op = mips_pkg::alu_srl;
                    mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_xor:  ctrl.alu_op = mips_pkg::alu_xor;
                    mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_sltu: ctrl.alu_op = mips_pkg::alu_sltu;
                    mips_pkg::fn_jr: begin
                        ctrl.reg_dst_rd = 1'b0;
                        ctrl.reg_write  = 1'b0;
                        ctrl.jump       = 1'b1;
                        ctrl.jump_reg   = 1'b1;
                    end
                    default: begin
                        ctrl.reg_dst_rd = 1'b0;
                        ctrl.reg_write  = 1'b0;
                    end
                endcase
            end
            mips_pkg::op_j: ctrl.jump = 1'b1;
            mips_pkg::op_jal: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;  // ra gets pc plus 4
                ctrl.reg_write = 1'b1;
            end
            mips_pkg::op_beq: begin
                ctrl.alu_op    = mips_pkg::alu_sub;
                ctrl.branch_eq = 1'b1;
            end
            mips_pkg::op_bne: begin
                ctrl.alu_op    = mips_pkg::alu_sub;
                ctrl.branch_ne = 1'b1;
            end
            mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu,
            mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                case (mips_pkg::opcode_e'(instr[31:26]))
                    mips_pkg::op_slti:  ctrl.alu_op = mips_pkg::alu_slt;
                    mips_pkg::op_sltiu: ctrl.alu_op = mips_pkg::alu_sltu;
                    mips_pkg::op_andi:  ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::op_ori:   ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::op_xori:  ctrl.alu_op = mips_pkg::alu_xor;
                    mips_pkg::op_lui:   ctrl.alu_op = mips_pkg::alu_lui;
                    default:            ctrl.alu_op = mips_pkg::alu_add;
                endcase
                // logical immediates are zero extended
                ctrl.imm_zero_ext = (ctrl.alu_op inside {mips_pkg::alu_and,
                                     mips_pkg::alu_or, mips_pkg::alu_xor});
            end
            mips_pkg::op_lb, mips_pkg::op_lw, mips_pkg::op_lbu: begin
                ctrl.alu_src_imm   = 1'b1;  // base plus offset
                ctrl.reg_write     = 1'b1;
                ctrl.mem_read      = 1'b1;
                ctrl.mem_byte      = (instr[31:26] != mips_pkg::op_lw);
                ctrl.load_unsigned = (instr[31:26] == mips_pkg::op_lbu);
            end
            mips_pkg::op_sb, mips_pkg::op_sw: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                ctrl.mem_byte    = (instr[31:26] == mips_pkg::op_sb);
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== source/fetch_sequencer.sv ====
`timescale 1ns/100ps

module fetch_sequencer (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 waitrequest,
    input  mips_pkg::word_t      readdata,
    input  mips_pkg::ctrl_t      ctrl,
    input  logic                 zero,
    input  mips_pkg::word_t      rs_data,
    output mips_pkg::cpu_state_e state,
    output mips_pkg::word_t      pc,
    output mips_pkg::word_t      instr,
    output logic                 active
);

    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t branch_target;
    mips_pkg::word_t jump_target;
    mips_pkg::word_t next_pc;
    logic            branch_taken;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};
    assign branch_taken  = (ctrl.branch_eq && zero) || (ctrl.branch_ne && !zero);

    always_comb begin
        if (ctrl.jump_reg) begin
            next_pc = rs_data;
        end else if (ctrl.jump) begin
            next_pc = jump_target;
        end else if (branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // instruction register, loaded when the fetch read completes
    always_ff @(posedge clk) begin
        if (state == mips_pkg::st_fetch && !waitrequest) begin
            instr <= readdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= mips_pkg::st_halt;
            pc     <= mips_pkg::reset_vector;
            active <= 1'b0;
        end else begin
            case (state)
                mips_pkg::st_halt: begin
                    // pc of 0 means the program finished and the core waits for reset
                    if (pc != '0) begin
                        state  <= mips_pkg::st_fetch;
                        active <= 1'b1;
                    end
                end
                mips_pkg::st_fetch: begin
                    if (!waitrequest) state <= mips_pkg::st_decode;
                end
                mips_pkg::st_decode: state <= mips_pkg::st_exec;
                mips_pkg::st_exec: begin
                    pc <= next_pc;
                    if (next_pc == '0) begin
                        state  <= mips_pkg::st_halt;
                        active <= 1'b0;
                    end else if (ctrl.mem_read || ctrl.mem_write) begin
                        state <= mips_pkg::st_mem;
                    end else begin
                        state <= mips_pkg::st_fetch;
                    end
                end
                mips_pkg::st_mem: begin
                    if (!waitrequest) state <= mips_pkg::st_fetch;
                end
                default: state <= mips_pkg::st_halt;
            endcase
        end
    end

    // active is high exactly while the fsm is out of halt
    a_active_in_run: assert property (@(posedge clk) disable iff (!arst_n)
        active == (state != mips_pkg::st_halt));

endmodule

// ==== source/load_store_unit.sv ====
`timescale 1ns/100ps

module load_store_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  mips_pkg::cpu_state_e state,
    input  mips_pkg::ctrl_t      ctrl,
    input  mips_pkg::word_t      pc,
    input  mips_pkg::word_t      instr,
    input  mips_pkg::word_t      alu_result,
    input  mips_pkg::word_t      rt_data,
    input  mips_pkg::word_t      readdata,
    input  logic                 waitrequest,
    output mips_pkg::word_t      address,
    output logic                 read,
    output logic                 write,
    output mips_pkg::word_t      writedata,
    output mips_pkg::byte_en_t   byteenable,
    output mips_pkg::reg_idx_t   rd_idx,
    output logic                 write_enable,
    output mips_pkg::word_t      write_data
);

    logic            in_mem;
    logic [7:0]      load_byte;
    mips_pkg::word_t load_data;

    assign in_mem  = (state == mips_pkg::st_mem);
    assign address = in_mem ? alu_result : pc;  // data access or fetch
    assign read    = (state == mips_pkg::st_fetch) || (in_mem && ctrl.mem_read);
    assign write   = in_mem && ctrl.mem_write;

    // byte store goes out on every lane and the enable picks one
    assign writedata  = ctrl.mem_byte ? {4{rt_data[7:0]}} : rt_data;
    assign byteenable = (in_mem && ctrl.mem_byte)
                      ? mips_pkg::byte_en_t'(4'b0001 << alu_result[1:0])
                      : 4'b1111;

    assign load_byte = readdata[8*alu_result[1:0] +: 8];
    always_comb begin
        if (!ctrl.mem_byte) begin
            load_data = readdata;
        end else if (ctrl.load_unsigned) begin
            load_data = {24'h000000, load_byte};
        end else begin
            load_data = {{24{load_byte[7]}}, load_byte};  // lb
        end
    end

    always_comb begin
        if (ctrl.mem_read) write_data = load_data;
        else if (ctrl.link) write_data = pc + 32'd4;  // pc still holds jal address
        else write_data = alu_result;
    end

    assign rd_idx = ctrl.link ? mips_pkg::ra_index :
                    ctrl.reg_dst_rd ? instr[15:11] : instr[20:16];

    // alu results land at the end of exec and loads when the read completes
    assign write_enable = ctrl.reg_write &&
                          ((state == mips_pkg::st_exec && !ctrl.mem_read) ||
                           (in_mem && ctrl.mem_read && !waitrequest));

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!arst_n) !(read && write));
    a_fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (state == mips_pkg::st_fetch) |-> (address[1:0] == 2'b00));
    // word stores also need an aligned address
    a_wr_lanes: assert property (@(posedge clk) disable iff (!arst_n)
        write |-> (byteenable != '0) && (ctrl.mem_byte || address[1:0] == 2'b00));

endmodule

// ==== source/mips_cpu_bus.sv ====
`timescale 1ns/100ps

module mips_cpu_bus (
    input  logic                clk,
    input  logic                arst_n,
    output logic                active,
    output mips_pkg::word_t     register_v0,
    // avalon master
    output mips_pkg::word_t     address,
    output logic                read,
    output logic                write,
    output mips_pkg::word_t     writedata,
    output mips_pkg::byte_en_t  byteenable,
    input  logic                waitrequest,
    input  mips_pkg::word_t     readdata
);

    mips_pkg::cpu_state_e state;
    mips_pkg::word_t      pc;
    mips_pkg::word_t      instr;
    mips_pkg::ctrl_t      ctrl;
    mips_pkg::word_t      rs_data;
    mips_pkg::word_t      rt_data;
    mips_pkg::word_t      imm_ext;
    mips_pkg::word_t      alu_b;
    mips_pkg::word_t      alu_result;
    logic                 zero;
    mips_pkg::reg_idx_t   rd_idx;
    logic                 write_enable;
    mips_pkg::word_t      write_data;

    fetch_sequencer u_fetch (
        .clk, .arst_n, .waitrequest, .readdata, .ctrl, .zero, .rs_data,
        .state, .pc, .instr, .active
    );

    control_decoder u_decode (.instr, .ctrl);

    register_file u_regs (
        .clk, .arst_n,
        .rs_idx(instr[25:21]), .rt_idx(instr[20:16]), .rd_idx,
        .write_enable, .write_data,
        .rs_data, .rt_data, .register_v0
    );

    // b operand is rt or the extended immediate
    assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, instr[15:0]}
                                       : {{16{instr[15]}}, instr[15:0]};
    assign alu_b   = ctrl.alu_src_imm ? imm_ext : rt_data;

    alu u_alu (
        .a(rs_data), .b(alu_b), .shamt(instr[10:6]), .op(ctrl.alu_op),
        .result(alu_result), .zero
    );

    load_store_unit u_lsu (
        .clk, .arst_n, .state, .ctrl, .pc, .instr, .alu_result, .rt_data,
        .readdata, .waitrequest,
        .address, .read, .write, .writedata, .byteenable,
        .rd_idx, .write_enable, .write_data
    );

endmodule

// ==== source/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;     // data, address or instruction
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;  // avalon byte lanes

    localparam word_t    reset_vector = 32'hBFC00000;
    localparam reg_idx_t v0_index     = 5'd2;
    localparam reg_idx_t ra_index     = 5'd31;  // link register for jal

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0A,
        op_sltiu   = 6'h0B,
        op_andi    = 6'h0C,
        op_ori     = 6'h0D,
        op_xori    = 6'h0E,
        op_lui     = 6'h0F,
        op_lb      = 6'h20,
        op_lw      = 6'h23,
        op_lbu     = 6'h24,
        op_sb      = 6'h28,
        op_sw      = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2A,
        fn_sltu = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        st_halt, st_fetch, st_decode, st_exec, st_mem
    } cpu_state_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;    // b operand is the immediate
        logic    imm_zero_ext;
        logic    reg_dst_rd;     // write rd instead of rt
        logic    link;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_byte;
        logic    load_unsigned;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    jump_reg;
    } ctrl_t;

endpackage

// ==== source/register_file.sv ====
`timescale 1ns/100ps

module register_file (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::reg_idx_t rd_idx,
    input  logic               write_enable,
    input  mips_pkg::word_t    write_data,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    register_v0
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd_idx != '0) begin  // r0 stays zero
            regs[rd_idx] <= write_data;
        end
    end

    // asynchronous read ports
    assign rs_data     = regs[rs_idx];
    assign rt_data     = regs[rt_idx];
    assign register_v0 = regs[mips_pkg::v0_index];

endmodule
